// ==== rtl/bch_pkg.sv ====
`default_nettype none

package bch_pkg;

	localparam int GF_M = 4;                       // Bits per element of GF(2^4).
	localparam int CODE_N = 15;                    // Code length, 2^GF_M - 1.
	localparam logic [GF_M:0] PRIM_POLY = 5'b1_0011; // The polynomial x^4 + x + 1.

	typedef logic [GF_M-1:0] gf_elem_t;

	// Shift-and-add product, reduced after every shift so the partial
	// product never leaves the field.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		logic [GF_M:0] shifted;
		gf_elem_t acc;
		shifted = {1'b0, a};
		acc = '0;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i]) begin
				acc ^= shifted[GF_M-1:0];
			end
			shifted = shifted << 1;
			if (shifted[GF_M]) begin
				shifted ^= PRIM_POLY; // Fold x^4 back into the field.
			end
		end
		return acc;
	endfunction

	// Alpha is the element x, so each step is one multiply by 4'b0010.
	function automatic gf_elem_t gf_alpha_pow(input int unsigned exp_val);
		gf_elem_t acc;
		int unsigned steps;
		acc = gf_elem_t'(1);
		steps = exp_val % CODE_N;         // The multiplicative group has order 15.
		for (int unsigned k = 0; k < steps; k++) begin
			acc = gf_mul(acc, gf_elem_t'(2));
		end
		return acc;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        in_valid,
	input  logic [bch_pkg::CODE_N-1:0]  in_word,
	output logic                        in_credit,
	output logic                        fifo_valid,
	output logic [bch_pkg::CODE_N-1:0]  fifo_word,
	input  logic                        pop
);
	import bch_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CODE_N-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// Pointers wrap explicitly so DEPTH need not be a power of two.
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_word; // The sender's credit guarantees a free slot.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			in_credit <= pop;                  // One credit back per entry released.
		end
	end

	assign fifo_valid = (count != '0);         // A write shows up one cycle later.
	assign fifo_word  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== rtl/codeword_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module codeword_serializer (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        fifo_valid,
	input  logic [bch_pkg::CODE_N-1:0]  fifo_word,
	output logic                        pop,
	input  logic                        hold_full,
	output logic                        bit_valid,
	output logic                        bit_data,
	output logic                        bit_first,
	output logic                        bit_last
);
	import bch_pkg::*;

	localparam int CNT_W = $clog2(CODE_N);

	logic [CODE_N-1:0] shreg;
	logic [CNT_W-1:0]  bit_cnt;
	logic              busy;
	logic              at_last;

	assign at_last = busy && (bit_cnt == CNT_W'(CODE_N - 1));

	// A new word may start when idle or on the last bit of the current one,
	// so consecutive words stream with no gap between them.
	assign pop = fifo_valid && !hold_full && (!busy || at_last);

	always_ff @(posedge clk) begin
		if (pop) begin
			shreg <= fifo_word;
		end else if (busy) begin
			shreg <= {shreg[CODE_N-2:0], 1'b0}; // Highest degree leaves first.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
		end else if (pop) begin
			busy    <= 1'b1;
			bit_cnt <= '0;
		end else if (at_last) begin
			busy    <= 1'b0;
		end else if (busy) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	assign bit_valid = busy;
	assign bit_data  = shreg[CODE_N-1];
	assign bit_first = busy && (bit_cnt == '0);
	assign bit_last  = at_last;

endmodule

`default_nettype wire

// ==== rtl/syndrome_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

module syndrome_cell #(
	parameter int J = 1
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              bit_valid,
	input  logic              bit_data,
	input  logic              bit_first,
	output bch_pkg::gf_elem_t syn
);
	import bch_pkg::*;

	localparam gf_elem_t ALPHA_J = gf_alpha_pow(J); // Evaluation point alpha^J.

	// Horner step, S = S * alpha^J + r_i, with the new bit as constant term.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			syn <= '0;
		end else if (bit_valid) begin
			if (bit_first) begin
				syn <= {{(GF_M-1){1'b0}}, bit_data};
			end else begin
				syn <= gf_mul(syn, ALPHA_J) ^ {{(GF_M-1){1'b0}}, bit_data};
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/syndrome_collector.sv ====
`timescale 1ns/10ps
`default_nettype none

module syndrome_collector #(
	parameter int T           = 3,
	parameter int OUT_CREDITS = 2
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            bit_last,
	input  logic [2*T*bch_pkg::GF_M-1:0]    cell_syn,
	output logic                            hold_full,
	output logic                            out_valid,
	output logic [2*T*bch_pkg::GF_M-1:0]    out_syndromes,
	output logic                            out_error,
	input  logic                            out_credit
);
	import bch_pkg::*;

	localparam int SYN_W = 2 * T * GF_M;
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	logic              pend;       // Cells hold a finished word not yet captured.
	logic              hold_valid; // Holding register has an unsent result.
	logic              send;
	logic              capture;
	logic [CRD_W-1:0]  credits;
	logic [SYN_W-1:0]  hold_syn;
	logic              hold_err;

	assign send    = hold_valid && (credits != '0);
	assign capture = pend && (!hold_valid || send); // A send frees the slot at once.

	// The cells must not take a new word while their finished one has nowhere
	// to go. bit_last looks one cycle ahead so a back-to-back word is held off
	// before its first bit reaches the cells.
	assign hold_full = hold_valid && (pend || bit_last);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend       <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (bit_last) begin
				pend <= 1'b1;              // Cells show final values next cycle.
			end else if (capture) begin
				pend <= 1'b0;
			end
			if (capture) begin
				hold_valid <= 1'b1;
			end else if (send) begin
				hold_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= CRD_W'(OUT_CREDITS);
		end else begin
			case ({send, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // Send and return cancel out.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			hold_syn <= cell_syn;
			hold_err <= |cell_syn;            // Any nonzero syndrome means errors.
		end
	end

	assign out_valid     = send;
	assign out_syndromes = hold_syn;
	assign out_error     = hold_err;

endmodule

`default_nettype wire

// ==== rtl/bch_syndrome_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_syndrome_top #(
	parameter int T           = 3,
	parameter int IN_DEPTH    = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            in_valid,
	input  logic [bch_pkg::CODE_N-1:0]      in_word,
	output logic                            in_credit,
	output logic                            out_valid,
	output logic [2*T*bch_pkg::GF_M-1:0]    out_syndromes,
	output logic                            out_error,
	input  logic                            out_credit
);
	import bch_pkg::*;

	logic              fifo_valid;
	logic [CODE_N-1:0] fifo_word;
	logic              pop;
	logic              hold_full;
	logic              bit_valid;
	logic              bit_data;
	logic              bit_first;
	logic              bit_last;
	logic [2*T*GF_M-1:0] cell_syn;  // S1 sits in the lowest element.

	credit_fifo #(
		.DEPTH(IN_DEPTH)
	) i_credit_fifo (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_word    (in_word),
		.in_credit  (in_credit),
		.fifo_valid (fifo_valid),
		.fifo_word  (fifo_word),
		.pop        (pop)
	);

	codeword_serializer i_codeword_serializer (
		.clk        (clk),
		.arst_n     (arst_n),
		.fifo_valid (fifo_valid),
		.fifo_word  (fifo_word),
		.pop        (pop),
		.hold_full  (hold_full),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.bit_first  (bit_first),
		.bit_last   (bit_last)
	);

	// One Horner cell per syndrome, evaluated at alpha^1 through alpha^2T.
	for (genvar j = 1; j <= 2 * T; j++) begin : g_cell
		syndrome_cell #(
			.J(j)
		) i_syndrome_cell (
			.clk       (clk),
			.arst_n    (arst_n),
			.bit_valid (bit_valid),
			.bit_data  (bit_data),
			.bit_first (bit_first),
			.syn       (cell_syn[(j-1)*GF_M +: GF_M])
		);
	end

	syndrome_collector #(
		.T           (T),
		.OUT_CREDITS (OUT_CREDITS)
	) i_syndrome_collector (
		.clk           (clk),
		.arst_n        (arst_n),
		.bit_last      (bit_last),
		.cell_syn      (cell_syn),
		.hold_full     (hold_full),
		.out_valid     (out_valid),
		.out_syndromes (out_syndromes),
		.out_error     (out_error),
		.out_credit    (out_credit)
	);

endmodule

`default_nettype wire

// ==== verification/bch_syndrome_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_syndrome_props #(
	parameter int T           = 3,
	parameter int OUT_CREDITS = 2
) (
	input logic                                 clk,
	input logic                                 arst_n,
	input logic                                 out_valid,
	input logic [2*T*bch_pkg::GF_M-1:0]         out_syndromes,
	input logic                                 out_error,
	input logic                                 out_credit,
	input logic [$clog2(OUT_CREDITS + 1)-1:0]   credits
);
	import bch_pkg::*;

	int port_credits; // Credits held as seen from the output port alone.

	// Squaring is linear in GF(2^4); x^4 folds to x+1 and x^6 to x^3+x^2.
	function automatic gf_elem_t square_elem(input gf_elem_t a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			port_credits <= OUT_CREDITS;
		end else begin
			port_credits <= port_credits - (out_valid ? 1 : 0) + (out_credit ? 1 : 0);
		end
	end

	a_send_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> port_credits > 0)
		else $error("Result sent with no output credit left.");

	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= OUT_CREDITS)
		else $error("Output credit count went above its reset value.");

	a_error_is_or: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> out_error == (|out_syndromes))
		else $error("Error flag differs from the OR of the syndromes.");

	a_s2_is_s1_squared: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> out_syndromes[2*GF_M-1:GF_M] == square_elem(out_syndromes[GF_M-1:0]))
		else $error("S2 is not the square of S1.");

endmodule

`default_nettype wire

// ==== verification/tb_bch_syndrome.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bch_syndrome;
	import bch_pkg::*;

	localparam int T           = 3;
	localparam int IN_DEPTH    = 4;
	localparam int OUT_CREDITS = 2;
	localparam int SYN_W       = 2 * T * GF_M;
	localparam int NUM_WORDS   = 60;
	localparam int MAX_CYCLES  = 5000;
	localparam int DRAIN_LIMIT = 500;
	localparam logic [31:0] SEED       = 32'h20af7ede;
	localparam logic [10:0] GEN_POLY   = 11'b101_0011_0111; // x^10+x^8+x^5+x^4+x^2+x+1.
	localparam logic [4:0]  FIELD_POLY = 5'b1_0011;          // x^4+x+1.

	logic              clk;
	logic              arst_n;
	logic              in_valid;
	logic [CODE_N-1:0] in_word;
	logic              in_credit;
	logic              out_valid;
	logic [SYN_W-1:0]  out_syndromes;
	logic              out_error;
	logic              out_credit;

	logic [GF_M-1:0]   alpha_tab [CODE_N];
	logic [31:0]       rng;
	logic [CODE_N-1:0] sent_q [$];
	int                kind_q [$]; // 0 random, 1 codeword, 2 codeword with flipped bits.
	int                in_credits;
	int                owed_credits;
	int                words_sent;
	int                results_seen;
	int                cycle;

	bch_syndrome_top #(
		.T           (T),
		.IN_DEPTH    (IN_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) i_bch_syndrome_top (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_word       (in_word),
		.in_credit     (in_credit),
		.out_valid     (out_valid),
		.out_syndromes (out_syndromes),
		.out_error     (out_error),
		.out_credit    (out_credit)
	);

	bind syndrome_collector bch_syndrome_props #(
		.T           (T),
		.OUT_CREDITS (OUT_CREDITS)
	) i_props (
		.clk           (clk),
		.arst_n        (arst_n),
		.out_valid     (out_valid),
		.out_syndromes (out_syndromes),
		.out_error     (out_error),
		.out_credit    (out_credit),
		.credits       (credits)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// Polynomial product of the message and the generator over GF(2).
	function automatic logic [CODE_N-1:0] encode_message(input logic [4:0] msg);
		logic [CODE_N-1:0] c;
		c = '0;
		for (int i = 0; i < 5; i++) begin
			if (msg[i]) c ^= CODE_N'(GEN_POLY) << i;
		end
		return c;
	endfunction

	// S_j is the sum of alpha^(i*j) over every set bit i of the word.
	function automatic logic [SYN_W-1:0] expected_syndromes(input logic [CODE_N-1:0] r);
		logic [SYN_W-1:0] res;
		logic [GF_M-1:0]  s;
		res = '0;
		for (int j = 1; j <= 2 * T; j++) begin
			s = '0;
			for (int i = 0; i < CODE_N; i++) begin
				if (r[i]) s ^= alpha_tab[(i * j) % CODE_N];
			end
			res[(j-1)*GF_M +: GF_M] = s;
		end
		return res;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic make_word(output logic [CODE_N-1:0] w, output int kind);
		logic [CODE_N-1:0] mask;
		int                nflips;
		rng = xorshift32(rng);
		kind = int'(rng % 3);
		rng = xorshift32(rng);
		w = (kind == 0) ? rng[CODE_N-1:0] : encode_message(rng[4:0]);
		nflips = 1 + int'(rng[20:16] % 3);
		mask = '0;
		if (kind == 2) begin
			while ($countones(mask) < nflips) begin
				rng = xorshift32(rng);
				mask[rng % CODE_N] = 1'b1;
			end
		end
		w ^= mask; // Distinct positions, so 1 to 3 real bit errors.
	endtask

	task automatic sample_outputs();
		logic [CODE_N-1:0] w;
		logic [SYN_W-1:0]  exp_syn;
		int                k;
		if (in_credit) begin
			assert (in_credits < IN_DEPTH)
				else stop_with_failure("More input credits were returned than words sent.");
			in_credits++;
		end
		if (out_valid) begin
			assert (sent_q.size() > 0)
				else stop_with_failure("A result came out with no word outstanding.");
			w = sent_q.pop_front();
			k = kind_q.pop_front();
			exp_syn = expected_syndromes(w);
			assert (out_syndromes === exp_syn)
				else stop_with_failure($sformatf("MISMATCH at %0t: word %h gave syndromes %h, expected %h",
					$time, w, out_syndromes, exp_syn));
			assert (out_error === (exp_syn != '0))
				else stop_with_failure($sformatf("MISMATCH at %0t: word %h gave error flag %b",
					$time, w, out_error));
			if (k == 1) begin
				assert (out_syndromes === '0 && out_error === 1'b0)
					else stop_with_failure($sformatf("MISMATCH at %0t: codeword %h flagged as bad",
						$time, w));
			end
			if (k == 2) begin
				assert (out_error === 1'b1)
					else stop_with_failure($sformatf("MISMATCH at %0t: corrupted word %h not flagged",
						$time, w));
			end
			results_seen++;
			owed_credits++;
		end
	endtask

	task automatic drive_inputs();
		logic [CODE_N-1:0] w;
		int                k;
		int                thresh;
		in_valid   = 1'b0;
		out_credit = 1'b0;
		rng = xorshift32(rng);
		if (words_sent < NUM_WORDS && in_credits > 0 && rng[1:0] != 2'b00) begin
			make_word(w, k);
			in_valid = 1'b1;
			in_word  = w;
			sent_q.push_back(w);
			kind_q.push_back(k);
			in_credits--;
			words_sent++;
		end
		// Credit return rate cycles through fast, none and slow phases.
		case ((cycle / 150) % 3)
			0:       thresh = 6;
			1:       thresh = 0;
			default: thresh = 2;
		endcase
		rng = xorshift32(rng);
		if (owed_credits > 0 && int'(rng[2:0]) < thresh) begin
			out_credit = 1'b1;
			owed_credits--;
		end
	endtask

	initial begin
		logic [GF_M:0] v;
		in_valid     = 1'b0;
		in_word      = '0;
		out_credit   = 1'b0;
		arst_n       = 1'b0;
		rng          = SEED;
		in_credits   = IN_DEPTH;
		owed_credits = 0;
		words_sent   = 0;
		results_seen = 0;
		cycle        = 0;
		v = 5'b00001;
		for (int k = 0; k < CODE_N; k++) begin
			alpha_tab[k] = v[GF_M-1:0];
			v = v << 1;
			if (v[GF_M]) v ^= FIELD_POLY;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			assert (!in_credit && !out_valid)
				else stop_with_failure("An output went active after reset with no input applied.");
		end
		while (results_seen < NUM_WORDS) begin
			if (cycle >= MAX_CYCLES) stop_with_failure("Timed out waiting for all results.");
			@(negedge clk);
			cycle++;
			sample_outputs();
			drive_inputs();
		end
		for (int c = 0; in_credits != IN_DEPTH || owed_credits != 0; c++) begin
			if (c >= DRAIN_LIMIT) stop_with_failure("Timed out waiting for credits to settle.");
			@(negedge clk);
			cycle++;
			sample_outputs();
			drive_inputs();
		end
		repeat (20) begin
			@(negedge clk);
			sample_outputs(); // Any extra result trips the empty queue check.
			in_valid   = 1'b0;
			out_credit = 1'b0;
		end
		if (results_seen == NUM_WORDS && sent_q.size() == 0 && in_credits == IN_DEPTH) begin
			$display("Test OK");
			$finish;
		end else begin
			stop_with_failure("Final counts of results or credits are wrong.");
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/bch_pkg.sv
rtl/credit_fifo.sv
rtl/codeword_serializer.sv
rtl/syndrome_cell.sv
rtl/syndrome_collector.sv
rtl/bch_syndrome_top.sv
verification/bch_syndrome_props.sv
verification/tb_bch_syndrome.sv
